// File: ecfg_config.svh
/*
 register map and reset values for the link configuration register file
 included by the bus package and by each register block
 word indices are taken from address bits 6:2
*/
`ifndef ECFG_CONFIG_SVH
`define ECFG_CONFIG_SVH

// ##############################
// address field
// ##############################
`define ECFG_RFAW 5                  // word index width, 32 slots

// ##############################
// word indices (ECFG_RFAW wide)
// ##############################
`define ELRESET    5'd0              // soft reset
`define ELCLK      5'd1              // clock divider
`define ELCOREID   5'd2              // core id
`define ELVERSION  5'd3              // read only
`define ELTX       5'd4              // tx control
`define ELRX       5'd5              // rx control
`define ELDATAOUT  5'd6              // gpio out
`define ELDATAIN   5'd7              // sampled gpio in
`define ELDEBUG    5'd8              // tx debug + sticky
`define ELRXDEBUG  5'd9              // rx debug + sticky

// ##############################
// reset values
// ##############################
`define ECFG_DEFAULT_COREID  12'h808
`define ECFG_DEFAULT_VERSION 16'h0000
`define ECFG_DEFAULT_CLKDIV  4'd7

`endif

// File: mi_bus_pkg.sv
/*
 memory interface bus types
 byte address, data word and the decoded word index
 imported by the bus bundle and the register blocks
*/
`include "ecfg_config.svh"

package mi_bus_pkg;

   // full physical byte address, no shifting on the bus
   typedef logic [19:0] mi_addr_t;

   // single write strobe, whole words only
   typedef logic [31:0] mi_data_t;

   // word index, address bits ECFG_RFAW+1:2
   typedef logic [`ECFG_RFAW-1:0] reg_idx_t;

endpackage

// File: ecfg_regs_pkg.sv
/*
 register field types for the configuration register file
 shared by the base, tx and rx blocks and the top level
 also holds the packing of the debug readback word
*/

package ecfg_regs_pkg;

   // tx control
   // [0] enable  [1] mmu enable  [3:2] mode  [7:4] ctrlmode  [8] ctrlmode bypass
   typedef logic [8:0] tx_cfg_t;

   // rx control
   // [0] enable  [1] mmu enable  [3:2] mode  [4] filter enable
   // mode 01 gpio capture, 10 loopback test
   typedef logic [4:0] rx_cfg_t;

   typedef logic [8:0]  gpio_t;      // dataout and datain pins
   typedef logic [15:0] debug_t;     // raw debug vector
   typedef logic [2:0]  sticky_t;    // latched low debug bits
   typedef logic [3:0]  ctrlmode_t;  // emesh ctrlmode tag
   typedef logic [11:0] coreid_t;
   typedef logic [3:0]  clkdiv_t;

   // debug readback
   // upper bits live, low three from the sticky register
   function automatic debug_t debug_word(input debug_t live, input sticky_t flags);
      debug_t word;
      word = {live[15:3], flags};
      return word;
   endfunction

endpackage

// File: mi_if.sv
/*
 memory interface bundle between the top level and the register blocks
 top level drives it through master, each block listens on slave
 readback does not travel here, every block returns its own dout
*/
`timescale 1ns/1ps

interface mi_if
   import mi_bus_pkg::*;
();

   logic     en;     // access strobe
   logic     we;     // high = write, low = read
   mi_addr_t addr;   // byte address
   mi_data_t din;    // write data

   // bus owner
   modport master (
      output en,
      output we,
      output addr,
      output din
   );

   // register blocks
   modport slave (
      input en,
      input we,
      input addr,
      input din
   );

endinterface

// File: ecfg_base.sv
/*
 base registers of the link configuration file
 soft reset, clock divider, core id and the read only version word
 readback is registered one cycle after the read strobe
*/
`timescale 1ns/1ps
`include "ecfg_config.svh"

module ecfg_base
   import mi_bus_pkg::*, ecfg_regs_pkg::*;
(
   input  logic     mi_clk,
   input  logic     reset,
   mi_if.slave      bus,
   output mi_data_t dout,
   output logic     soft_reset,
   output clkdiv_t  clkdiv,
   output coreid_t  coreid
);

   reg_idx_t idx;
   logic     wr;
   logic     rd;
   logic     reset_reg;
   clkdiv_t  clkdiv_reg;
   coreid_t  coreid_reg;

   // ##############################
   // decode
   // ##############################
   assign idx = bus.addr[`ECFG_RFAW+1:2];
   assign wr  = bus.en & bus.we;
   assign rd  = bus.en & ~bus.we;

   // ##############################
   // registers
   // ##############################
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         reset_reg  <= 1'b0;
         clkdiv_reg <= `ECFG_DEFAULT_CLKDIV;
         coreid_reg <= `ECFG_DEFAULT_COREID;
      end else if (wr) begin
         if (idx == `ELRESET) reset_reg  <= bus.din[0];
         if (idx == `ELCLK)   clkdiv_reg <= bus.din[3:0];   // high bits dropped
         if (idx == `ELCOREID) coreid_reg <= bus.din[11:0];
      end
   end

   assign soft_reset = reset_reg;
   assign clkdiv     = clkdiv_reg;
   assign coreid     = coreid_reg;

   // ##############################
   // readback
   // ##############################
   always_ff @(posedge mi_clk) begin
      if (rd) begin
         case (idx)
            `ELRESET:   dout <= {31'b0, reset_reg};
            `ELCLK:     dout <= {28'b0, clkdiv_reg};
            `ELCOREID:  dout <= {20'b0, coreid_reg};
            `ELVERSION: dout <= {16'b0, `ECFG_DEFAULT_VERSION};
            default:    dout <= '0;         // not ours, zero for the OR
         endcase
      end
   end

   // divider output tracks the low nibble of the last write
   a_clkdiv_trunc : assert property (@(posedge mi_clk) disable iff (reset)
      (wr && idx == `ELCLK) |=> (clkdiv == $past(bus.din[3:0])));

endmodule

// File: ecfg_tx.sv
/*
 transmit side configuration registers
 tx control word, gpio data-out and sticky tx debug flags
 control outputs decode straight from the stored word
*/
`timescale 1ns/1ps
`include "ecfg_config.svh"

module ecfg_tx
   import mi_bus_pkg::*, ecfg_regs_pkg::*;
(
   input  logic      mi_clk,
   input  logic      reset,
   mi_if.slave       bus,
   output mi_data_t  dout,
   input  debug_t    tx_debug,
   output logic      tx_enable,
   output logic      tx_mmu_enable,
   output logic      tx_gpio_enable,
   output logic      tx_tp_enable,
   output logic      tx_ctrlmode_bp,
   output ctrlmode_t tx_ctrlmode,
   output gpio_t     dataout
);

   reg_idx_t idx;
   logic     wr;
   logic     rd;
   tx_cfg_t  tx_reg;
   gpio_t    dataout_reg;
   sticky_t  sticky;

   assign idx = bus.addr[`ECFG_RFAW+1:2];
   assign wr  = bus.en & bus.we;
   assign rd  = bus.en & ~bus.we;

   // ##############################
   // tx control
   // ##############################
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         tx_reg <= '0;
      end else if (wr && idx == `ELTX) begin
         tx_reg <= bus.din[8:0];       // upper bits not stored
      end
   end

   assign tx_enable      = tx_reg[0];
   assign tx_mmu_enable  = tx_reg[1];
   assign tx_gpio_enable = (tx_reg[3:2] == 2'b01);   // pins forced to dataout
   assign tx_tp_enable   = (tx_reg[3:2] == 2'b10);   // 1/0 test pattern
   assign tx_ctrlmode    = tx_reg[7:4];
   assign tx_ctrlmode_bp = tx_reg[8];

   // ##############################
   // data-out and debug
   // ##############################
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         dataout_reg <= '0;
         sticky      <= '0;
      end else begin
         if (wr && idx == `ELDATAOUT) dataout_reg <= bus.din[8:0];
         sticky <= sticky | tx_debug[2:0];   // hold any pulse
      end
   end

   assign dataout = dataout_reg;

   // readback, one cycle after strobe
   always_ff @(posedge mi_clk) begin
      if (rd) begin
         case (idx)
            `ELTX:      dout <= {23'b0, tx_reg};
            `ELDATAOUT: dout <= {23'b0, dataout_reg};
            `ELDEBUG:   dout <= {16'b0, debug_word(tx_debug, sticky)};
            default:    dout <= '0;
         endcase
      end
   end

   // pins cannot be forced and patterned at once
   a_tx_mode_onehot : assert property (@(posedge mi_clk) disable iff (reset)
      !(tx_gpio_enable && tx_tp_enable));

endmodule

// File: ecfg_rx.sv
/*
 receive side configuration registers
 rx control word, sampled gpio data-in and sticky rx debug flags
 data-in is captured every cycle and read back from that capture
*/
`timescale 1ns/1ps
`include "ecfg_config.svh"

module ecfg_rx
   import mi_bus_pkg::*, ecfg_regs_pkg::*;
(
   input  logic     mi_clk,
   input  logic     reset,
   mi_if.slave      bus,
   output mi_data_t dout,
   input  debug_t   rx_debug,
   input  gpio_t    rx_datain,
   output logic     rx_enable,
   output logic     rx_mmu_enable,
   output logic     rx_gpio_enable,
   output logic     rx_loopback,
   output logic     rx_filter_enable
);

   reg_idx_t idx;
   logic     wr;
   logic     rd;
   rx_cfg_t  rx_reg;
   gpio_t    datain_reg;
   sticky_t  sticky;

   assign idx = bus.addr[`ECFG_RFAW+1:2];
   assign wr  = bus.en & bus.we;
   assign rd  = bus.en & ~bus.we;

   // ##############################
   // rx control
   // ##############################
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         rx_reg <= '0;
      end else if (wr && idx == `ELRX) begin
         rx_reg <= bus.din[4:0];
      end
   end

   assign rx_enable        = rx_reg[0];
   assign rx_mmu_enable    = rx_reg[1];
   assign rx_gpio_enable   = (rx_reg[3:2] == 2'b01);   // capture pins as gpio
   assign rx_loopback      = (rx_reg[3:2] == 2'b10);   // tx looped to rx
   assign rx_filter_enable = rx_reg[4];

   // ##############################
   // data-in and debug
   // ##############################
   // free running sample of the pins
   always_ff @(posedge mi_clk) begin
      datain_reg <= rx_datain;
   end

   always_ff @(posedge mi_clk) begin
      if (reset) begin
         sticky <= '0;
      end else begin
         sticky <= sticky | rx_debug[2:0];
      end
   end

   always_ff @(posedge mi_clk) begin
      if (rd) begin
         case (idx)
            `ELRX:      dout <= {27'b0, rx_reg};
            `ELDATAIN:  dout <= {23'b0, datain_reg};
            `ELRXDEBUG: dout <= {16'b0, debug_word(rx_debug, sticky)};
            default:    dout <= '0;
         endcase
      end
   end

   // a write with a floating address would land anywhere
   a_wr_addr_known : assert property (@(posedge mi_clk) disable iff (reset)
      (bus.en && bus.we) |-> !$isunknown(bus.addr));

endmodule

// File: ecfg_top.sv
/*
 top level of the link configuration register file
 maps the plain memory interface ports onto the bus bundle
 and merges the three block readbacks into mi_dout
*/
`timescale 1ns/1ps

module ecfg_top
   import mi_bus_pkg::*, ecfg_regs_pkg::*;
(
   input  logic      mi_clk,
   input  logic      reset,
   input  logic      mi_en,
   input  logic      mi_we,
   input  mi_addr_t  mi_addr,
   input  mi_data_t  mi_din,
   output mi_data_t  mi_dout,
   input  debug_t    tx_debug,
   input  debug_t    rx_debug,
   input  gpio_t     rx_datain,
   output logic      soft_reset,
   output clkdiv_t   clkdiv,
   output coreid_t   coreid,
   output logic      tx_enable,
   output logic      tx_mmu_enable,
   output logic      tx_gpio_enable,
   output logic      tx_tp_enable,
   output ctrlmode_t tx_ctrlmode,
   output logic      tx_ctrlmode_bp,
   output gpio_t     dataout,
   output logic      rx_enable,
   output logic      rx_mmu_enable,
   output logic      rx_gpio_enable,
   output logic      rx_loopback,
   output logic      rx_filter_enable
);

   mi_data_t base_dout;
   mi_data_t tx_dout;
   mi_data_t rx_dout;

   // ##############################
   // bus fan-out
   // ##############################
   mi_if bus_if ();

   assign bus_if.en   = mi_en;     // master side, one to one
   assign bus_if.we   = mi_we;
   assign bus_if.addr = mi_addr;
   assign bus_if.din  = mi_din;

   ecfg_base base_i (
      .mi_clk, .reset, .bus(bus_if.slave), .dout(base_dout),
      .soft_reset, .clkdiv, .coreid
   );

   ecfg_tx tx_i (
      .mi_clk, .reset, .bus(bus_if.slave), .dout(tx_dout), .tx_debug,
      .tx_enable, .tx_mmu_enable, .tx_gpio_enable, .tx_tp_enable,
      .tx_ctrlmode_bp, .tx_ctrlmode, .dataout
   );

   ecfg_rx rx_i (
      .mi_clk, .reset, .bus(bus_if.slave), .dout(rx_dout), .rx_debug, .rx_datain,
      .rx_enable, .rx_mmu_enable, .rx_gpio_enable, .rx_loopback, .rx_filter_enable
   );

   // unowned indices read zero in every block
   assign mi_dout = base_dout | tx_dout | rx_dout;

endmodule

// File: tb_ecfg.sv
/*
 testbench for the link configuration register file
 replays ecfg_trace.txt against the top level, one operation per line
 bus writes and reads, input changes, output checks and resets
*/
`timescale 1ns/1ps

module tb_ecfg
   import mi_bus_pkg::*, ecfg_regs_pkg::*;
();

   localparam int MAX_LINES  = 200;   // trace length limit
   localparam int RST_CYCLES = 4;

   logic      mi_clk = 1'b0;
   logic      reset, mi_en, mi_we;
   mi_addr_t  mi_addr;
   mi_data_t  mi_din, mi_dout;
   debug_t    tx_debug, rx_debug;
   gpio_t     rx_datain, dataout;
   logic      soft_reset, tx_enable, tx_mmu_enable, tx_gpio_enable, tx_tp_enable;
   logic      tx_ctrlmode_bp, rx_enable, rx_mmu_enable, rx_gpio_enable;
   logic      rx_loopback, rx_filter_enable;
   clkdiv_t   clkdiv;
   coreid_t   coreid;
   ctrlmode_t tx_ctrlmode;

   int checks = 0;
   int errors = 0;
   int tests = 0;
   int failed_tests = 0;
   int test_errors = 0;
   bit in_test = 1'b0;
   int fd;
   logic [8*16-1:0] test_name = '0;

   ecfg_top dut_i (.*);

   always #20 mi_clk = ~mi_clk;   // 40 ns period

   // ##############################
   // helpers
   // ##############################
   task automatic next_cycle();
      @(posedge mi_clk);
      #2;                          // drive and sample just past the edge
   endtask

   task automatic compare(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         test_errors++;
         $display("** Error: %s is %h, expected %h", name, actual, expected);
      end
   endtask

   task automatic end_test();
      if (in_test) begin
         tests++;
         if (test_errors == 0) begin
            $display("test %0s: ok", test_name);
         end else begin
            failed_tests++;
            $display("test %0s: %0d errors", test_name, test_errors);
         end
      end
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      for (int i = 0; i < RST_CYCLES; i++) begin
         next_cycle();
      end
      reset = 1'b0;
   endtask

   task automatic bus_write(input reg_idx_t idx, input mi_data_t data);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = {13'b0, idx, 2'b00};   // word index into bits 6:2
      mi_din  = data;
      next_cycle();
      mi_en   = 1'b0;
      mi_we   = 1'b0;
   endtask

   // dout is registered, valid one cycle after the strobe
   task automatic bus_read(input reg_idx_t idx, input mi_data_t expected);
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = {13'b0, idx, 2'b00};
      next_cycle();
      mi_en   = 1'b0;
      compare($sformatf("mi_dout at index %0h", idx), mi_dout, expected);
   endtask

   task automatic check_outputs(input logic [31:0] base, input logic [31:0] tx,
                                input logic [31:0] rx);
      compare("{soft_reset,clkdiv,coreid}", {15'b0, soft_reset, clkdiv, coreid}, base);
      compare("{dataout,tx_ctrlmode_bp,tx_ctrlmode,tx_tp/gpio/mmu/enable}",
              {14'b0, dataout, tx_ctrlmode_bp, tx_ctrlmode, tx_tp_enable,
               tx_gpio_enable, tx_mmu_enable, tx_enable}, tx);
      compare("{rx_filter_enable,rx_loopback,rx_gpio/mmu/enable}",
              {27'b0, rx_filter_enable, rx_loopback, rx_gpio_enable,
               rx_mmu_enable, rx_enable}, rx);
   endtask

   task automatic field_count(input int code, input int want, input int line_no);
      if (code != want) begin
         errors++;
         test_errors++;
         $display("trace line %0d has %0d fields where %0d were expected",
                  line_no, code, want);
      end
   endtask

   // ##############################
   // trace operations
   // ##############################
   task automatic run_op(input logic [7:0] op, input int line_no);
      int code;
      logic [31:0] a, b, c;
      logic [8*160-1:0] rest;
      case (op)
         "#": code = $fgets(rest, fd);    // comment, drop the rest
         "T": begin
            end_test();
            code = $fscanf(fd, "%s", test_name);
            in_test = 1'b1;
            test_errors = 0;
         end
         "W": begin
            code = $fscanf(fd, "%h %h", a, b);
            field_count(code, 2, line_no);
            bus_write(a[4:0], b);
         end
         "R": begin
            code = $fscanf(fd, "%h %h", a, b);
            field_count(code, 2, line_no);
            bus_read(a[4:0], b);
         end
         "I": begin
            code = $fscanf(fd, "%h %h %h", a, b, c);
            field_count(code, 3, line_no);
            tx_debug  = a[15:0];
            rx_debug  = b[15:0];
            rx_datain = c[8:0];
            next_cycle();                 // one sample edge
         end
         "O": begin
            code = $fscanf(fd, "%h %h %h", a, b, c);
            field_count(code, 3, line_no);
            check_outputs(a, b, c);
         end
         "X": apply_reset();
         default: begin
            errors++;
            test_errors++;
            $display("unknown trace operation on line %0d", line_no);
         end
      endcase
   endtask

   // ##############################
   // main sequence
   // ##############################
   initial begin
      int code;
      int lines;
      bit done;
      logic [8*16-1:0] word;
      reset     = 1'b1;
      mi_en     = 1'b0;
      mi_we     = 1'b0;
      mi_addr   = '0;
      mi_din    = '0;
      tx_debug  = '0;
      rx_debug  = '0;
      rx_datain = '0;
      apply_reset();
      fd = $fopen("ecfg_trace.txt", "r");
      if (fd == 0) begin
         $display("cannot open the trace file ecfg_trace.txt");
         $display("Verification failed");
         $finish;
      end else begin
         lines = 0;
         done  = 1'b0;
         while (!done) begin
            code = $fscanf(fd, "%s", word);
            if (code != 1) begin
               done = 1'b1;               // end of file
            end else if (lines >= MAX_LINES) begin
               errors++;
               $display("trace still running after %0d lines, run stopped", MAX_LINES);
               done = 1'b1;
            end else begin
               lines++;
               run_op(word[7:0], lines);
            end
         end
         $fclose(fd);
         end_test();
         $display("tests %0d, failed %0d, checks %0d, errors %0d",
                  tests, failed_tests, checks, errors);
         if (errors == 0) begin
            $display("Verification passed");
         end else begin
            $display("Verification failed");
         end
         $finish;
      end
   end

endmodule

// File: ecfg_trace.txt
# op and hex fields: W idx data | R idx dout | I tx_debug rx_debug rx_datain | X reset
# O {soft_reset,clkdiv,coreid} {dataout,bp,ctrlmode,tp,gpio,mmu,en} {filter,lb,gpio,mmu,en}
T reset_values
R 0 0
R 1 7
R 2 808
R 3 0
R 4 0
R 5 0
R 6 0
R 7 0
R 8 0
R 9 0
O 7808 0 0
T tx_decode
W 4 fffffe03
R 4 3
O 7808 3 0
W 4 95
O 7808 95 0
W 4 1a9
O 7808 1a9 0
W 4 ffff007e
R 4 7e
O 7808 72 0
T gpio_data
W 6 fffff15a
R 6 15a
O 7808 2b472 0
I 0 0 a5
R 7 a5
I 0 0 1ff
R 7 1ff
T sticky_debug
I 2 0 1ff
I a5f8 0 1ff
R 8 a5fa
I 0 4 1ff
I 0 3c00 1ff
R 9 3c04
I 0 0 1ff
R 8 2
R 9 4
X
R 8 0
R 9 0
O 7808 0 0
T rx_base
W 5 ffffffe5
O 7808 0 5
W 5 f
O 7808 0 3
W 5 1a
R 5 1a
O 7808 0 1a
W 0 1
R 0 1
W 1 ffffff3c
W 2 abcd5123
W 3 ffffffff
O 1c123 0 1a
R 1 c
R 3 0
R a 0
R 10 0
W 1f ffffffff
R 1f 0

// File: ecfg.f
+incdir+.
mi_bus_pkg.sv
ecfg_regs_pkg.sv
mi_if.sv
ecfg_base.sv
ecfg_tx.sv
ecfg_rx.sv
ecfg_top.sv
tb_ecfg.sv

// File: run_ecfg.sh
#!/bin/sh
# build the register file testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=run_ecfg.log

verilator --binary --timing --assert -f ecfg.f --top-module tb_ecfg -o tb_ecfg
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_ecfg > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
   exit 0
fi
echo "pass line not found in $LOG"
exit 1
